// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = wexDecodeTb
FILELIST = wexDecode.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== hdl/laneRouter.sv ====
/* bundle router
   picks scalar, WEX2, WEX3 or jumbo form and registers the three lanes */
`timescale 1ns/1ns
`include "wexDec_macros.svh"

module laneRouter import wexDecPkg::*; (
	input  logic      clock,
	input  logic      rstN,
	input  logic      fetchValid,
	input  logic      wexEnable,
	input  logic      lane3Enable,
	input  logic      isOp32S0,
	input  logic      isJumboS0,
	input  logic      wexFlagS0,
	input  jumboBitsT jumboBitsS0,
	input  regIdT     regNS0,
	input  regIdT     regMS0,
	input  regIdT     regOS0,
	input  immT       immS0,
	input  uCmdT      uCmdS0,
	input  uIxtT      uIxtS0,
	input  logic      isOp32S1,
	input  logic      wexFlagS1,
	input  regIdT     regNS1,
	input  regIdT     regMS1,
	input  regIdT     regOS1,
	input  immT       immS1,
	input  uCmdT      uCmdS1,
	input  uIxtT      uIxtS1,
	input  logic      isOp32S2,
	input  regIdT     regNS2,
	input  regIdT     regMS2,
	input  regIdT     regOS2,
	input  immT       immS2,
	input  uCmdT      uCmdS2,
	input  uIxtT      uIxtS2,
	output logic      decodeValid,
	output opWordsT   opWords,
	output regIdT     regNA, regMA, regOA,
	output immT       immA,
	output uCmdT      uCmdA,
	output uIxtT      uIxtA,
	output regIdT     regNB, regMB, regOB,
	output immT       immB,
	output uCmdT      uCmdB,
	output uIxtT      uIxtB,
	output regIdT     regNC, regMC, regOC,
	output immT       immC,
	output uCmdT      uCmdC,
	output uIxtT      uIxtC
);

	logic [`LANE_BITS-1:0] laneS0, laneS1, laneS2, laneJumbo, laneIdle, laneInv;
	logic [`LANE_BITS-1:0] nxtLaneA, nxtLaneB, nxtLaneC;
	logic [`LANE_BITS-1:0] laneRegA, laneRegB, laneRegC;
	opWordsT               nxtOpWords;
	logic                  wexLead;

	assign laneS0 = {regNS0, regMS0, regOS0, immS0, uCmdS0, uIxtS0};
	assign laneS1 = {regNS1, regMS1, regOS1, immS1, uCmdS1, uIxtS1};
	assign laneS2 = {regNS2, regMS2, regOS2, immS2, uCmdS2, uIxtS2};

	// prefix payload on top, then slot 1 bits 31:23 (imm bits 9:1)
	assign laneJumbo = {regNS1, regMS1, regOS1, immT'({jumboBitsS0, immS1[9:1]}), uCmdS1, uIxtS1};

	assign laneIdle = {`GR_ZZR, `GR_ZZR, `GR_ZZR, 33'd0, 9'd0, 9'd0};
	assign laneInv  = {`GR_ZZR, `GR_ZZR, `GR_ZZR, 33'd0, {`PCLS_UNCOND, `UCMD_INVOP}, 9'd0};

	// slot 0 opens a bundle
	assign wexLead = isOp32S0 && wexEnable && wexFlagS0 && isOp32S1;

	always_comb
	begin
		nxtLaneA   = laneInv;
		nxtLaneB   = laneIdle;
		nxtLaneC   = laneIdle;
		nxtOpWords = 2'd1;
		if (isJumboS0 && isOp32S1)
		begin
			nxtLaneA   = laneJumbo;
			nxtOpWords = 2'd2;
		end
		else if (wexLead && wexFlagS1 && lane3Enable && isOp32S2)
		begin
			nxtLaneA   = laneS2;  // last op in lane A
			nxtLaneB   = laneS1;
			nxtLaneC   = laneS0;
			nxtOpWords = 2'd3;
		end
		else if (wexLead)
		begin
			nxtLaneA   = laneS1;
			nxtLaneB   = laneS0;
			nxtOpWords = 2'd2;
		end
		else if (isOp32S0)
		begin
			nxtLaneA = laneS0;  // scalar
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			decodeValid <= 1'b0;
			opWords     <= '0;
			laneRegA    <= '0;
			laneRegB    <= '0;
			laneRegC    <= '0;
		end
		else
		begin
			decodeValid <= fetchValid;
			if (fetchValid)
			begin
				opWords  <= nxtOpWords;
				laneRegA <= nxtLaneA;
				laneRegB <= nxtLaneB;
				laneRegC <= nxtLaneC;
			end
		end
	end

	assign {regNA, regMA, regOA, immA, uCmdA, uIxtA} = laneRegA;
	assign {regNB, regMB, regOB, immB, uCmdB, uIxtB} = laneRegB;
	assign {regNC, regMC, regOC, immC, uCmdC, uIxtC} = laneRegC;

	opWordsRange: assert property (@(posedge clock) disable iff (!rstN)
		decodeValid |-> (opWords != 2'd0))
		else $error("bundle with zero slots consumed");

	// one pulse per strobe, so a long pulse needs back-to-back strobes
	pulsePerStrobe: assert property (@(posedge clock) disable iff (!rstN)
		decodeValid && $past(decodeValid) |-> $past(fetchValid) && $past(fetchValid, 2))
		else $error("decodeValid held without a matching strobe");

endmodule

// ==== hdl/modeReg.sv ====
/* WEX mode register
   holds the bundling and third-lane enables that steer the router */
`timescale 1ns/1ns
`include "wexDec_macros.svh"

module modeReg (
	input  logic       clock,
	input  logic       rstN,
	input  logic       modeWrite,
	input  logic       modeWexEnable,
	input  logic       modeLane3Enable,
	output logic       wexEnable,
	output logic       lane3Enable,
	output logic [1:0] modeRead
);

	logic [1:0] modeBits;  // {lane3Enable, wexEnable}

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			modeBits <= `MODE_RESET;
		end
		else if (modeWrite)
		begin
			// takes effect for strobes after this edge
			modeBits <= {modeLane3Enable, modeWexEnable};
		end
	end

	assign wexEnable   = modeBits[0];
	assign lane3Enable = modeBits[1];
	assign modeRead    = modeBits;

	// router selects bundles from these, so X here spreads to every lane
	modeKnown: assert property (@(posedge clock) disable iff (!rstN)
		!$isunknown({wexEnable, lane3Enable}))
		else $error("mode bits unknown out of reset");

endmodule

// ==== hdl/slotDecoder.sv ====
/* single slot decoder
   classifies one 32-bit slot and pulls out its register, immediate and command fields */
`timescale 1ns/1ns
`include "wexDec_macros.svh"

module slotDecoder import wexDecPkg::*; (
	input  slotWordT  slot,
	output logic      isOp32,
	output logic      isJumbo,
	output logic      wexFlag,
	output jumboBitsT jumboBits,
	output regIdT     regN,
	output regIdT     regM,
	output regIdT     regO,
	output immT       imm,
	output uCmdT      uCmd,
	output uIxtT      uIxt
);

	logic [2:0] predClass;

	// jumbo takes the top of the Fx space, so test it first
	assign isJumbo = (slot[15:9] == `JUMBO_TAG);
	assign isOp32  = (slot[15:13] == 3'b111) && !isJumbo;

	always_comb
	begin
		wexFlag   = 1'b0;
		predClass = `PCLS_UNCOND;
		if (isOp32)
		begin
			case (slot[15:12])
				`GRP_PRED:
				begin
					// Ex with bits 11 and 9 set is a predicated WEX op
					wexFlag   = slot[11] && slot[9];
					predClass = slot[10] ? `PCLS_FALSE : `PCLS_TRUE;
				end
				`GRP_UNCOND:
				begin
					wexFlag   = slot[10];
					predClass = `PCLS_UNCOND;
				end
				default:
				begin
					wexFlag   = 1'b0;
					predClass = `PCLS_UNCOND;
				end
			endcase
		end
	end

	// register fields
	assign regN = slot[21:16];
	assign regM = slot[27:22];
	assign regO = {slot[7:6], slot[31:28]};  // split field

	// 10-bit immediate, sign extended
	assign imm = {{23{slot[31]}}, slot[31:22]};

	assign uCmd = {predClass, slot[5:0]};
	assign uIxt = {1'b0, slot[7:0]};

	// only meaningful when isJumbo
	assign jumboBits = {slot[7:0], slot[31:16]};

endmodule

// ==== hdl/wexDecPkg.sv ====
/* WEX decoder types
   vector widths shared by the slot decoders, router and top */
package wexDecPkg;

	// one 32-bit instruction slot
	typedef logic [31:0] slotWordT;

	// three slots, slot 0 in the low word
	typedef logic [95:0] fetchWindowT;

	// register number, 64 entries
	typedef logic [5:0] regIdT;

	// immediate, sign in bit 32
	typedef logic [32:0] immT;

	// micro-command: {predicate class, opcode}
	typedef logic [8:0] uCmdT;

	// micro-extension
	typedef logic [8:0] uIxtT;

	// payload carried by a jumbo prefix
	typedef logic [23:0] jumboBitsT;

	// slots consumed by one bundle, 1 to 3
	typedef logic [1:0] opWordsT;

endpackage

// ==== hdl/wexDec_macros.svh ====
/* WEX bundle decoder encodings
   register numbers, group codes, predicate classes and mode defaults */
`ifndef WEXDEC_MACROS_SVH
`define WEXDEC_MACROS_SVH

// zero register, also the filler for idle lanes
`define GR_ZZR 6'd0

// op group in bits 15:12 of a 32-bit op
`define GRP_PRED   4'hE  // Ex, predicated
`define GRP_UNCOND 4'hF  // Fx, unconditional

// jumbo prefix tag in bits 15:9
`define JUMBO_TAG 7'h7F

// predicate class, top 3 bits of the micro-command
`define PCLS_UNCOND 3'd0
`define PCLS_TRUE   3'd2  // execute if T set
`define PCLS_FALSE  3'd3  // execute if T clear

// opcode given to anything that is not a 32-bit op
`define UCMD_INVOP 6'h3F

// one lane as {regN, regM, regO, imm, uCmd, uIxt}
`define LANE_BITS 69

// mode bits {lane3Enable, wexEnable} out of reset
`define MODE_RESET 2'b11

`endif

// ==== hdl/wexDecodeTop.sv ====
/* three-slot WEX bundle decoder
   mode register, per-slot decoders and the lane router */
`timescale 1ns/1ns

module wexDecodeTop import wexDecPkg::*; (
	input  logic        clock,
	input  logic        rstN,
	input  logic        fetchValid,
	input  fetchWindowT fetchWindow,
	input  logic        modeWrite,
	input  logic        modeWexEnable,
	input  logic        modeLane3Enable,
	output logic        decodeValid,
	output opWordsT     opWords,
	output regIdT       regNA, regMA, regOA,
	output immT         immA,
	output uCmdT        uCmdA,
	output uIxtT        uIxtA,
	output regIdT       regNB, regMB, regOB,
	output immT         immB,
	output uCmdT        uCmdB,
	output uIxtT        uIxtB,
	output regIdT       regNC, regMC, regOC,
	output immT         immC,
	output uCmdT        uCmdC,
	output uIxtT        uIxtC,
	output logic [1:0]  modeRead
);

	logic      wexEnable, lane3Enable;
	logic      isOp32 [3];
	logic      isJumbo [3];
	logic      wexFlag [3];
	jumboBitsT jumboBits [3];
	regIdT     regN [3], regM [3], regO [3];
	immT       imm [3];
	uCmdT      uCmd [3];
	uIxtT      uIxt [3];

	modeReg modeReg_inst (
		.clock(clock), .rstN(rstN), .modeWrite(modeWrite),
		.modeWexEnable(modeWexEnable), .modeLane3Enable(modeLane3Enable),
		.wexEnable(wexEnable), .lane3Enable(lane3Enable), .modeRead(modeRead)
	);

	for (genvar i = 0; i < 3; i++)
	begin : slotDec
		slotDecoder slotDecoder_inst (
			.slot(fetchWindow[32*i +: 32]),
			.isOp32(isOp32[i]), .isJumbo(isJumbo[i]), .wexFlag(wexFlag[i]),
			.jumboBits(jumboBits[i]), .regN(regN[i]), .regM(regM[i]), .regO(regO[i]),
			.imm(imm[i]), .uCmd(uCmd[i]), .uIxt(uIxt[i])
		);
	end

	// only slot 0 may carry a prefix; slot 2 flags never open a bundle
	laneRouter laneRouter_inst (
		.clock(clock), .rstN(rstN), .fetchValid(fetchValid),
		.wexEnable(wexEnable), .lane3Enable(lane3Enable),
		.isOp32S0(isOp32[0]), .isJumboS0(isJumbo[0]), .wexFlagS0(wexFlag[0]),
		.jumboBitsS0(jumboBits[0]), .regNS0(regN[0]), .regMS0(regM[0]), .regOS0(regO[0]),
		.immS0(imm[0]), .uCmdS0(uCmd[0]), .uIxtS0(uIxt[0]),
		.isOp32S1(isOp32[1]), .wexFlagS1(wexFlag[1]),
		.regNS1(regN[1]), .regMS1(regM[1]), .regOS1(regO[1]),
		.immS1(imm[1]), .uCmdS1(uCmd[1]), .uIxtS1(uIxt[1]),
		.isOp32S2(isOp32[2]),
		.regNS2(regN[2]), .regMS2(regM[2]), .regOS2(regO[2]),
		.immS2(imm[2]), .uCmdS2(uCmd[2]), .uIxtS2(uIxt[2]),
		.decodeValid(decodeValid), .opWords(opWords),
		.regNA(regNA), .regMA(regMA), .regOA(regOA),
		.immA(immA), .uCmdA(uCmdA), .uIxtA(uIxtA),
		.regNB(regNB), .regMB(regMB), .regOB(regOB),
		.immB(immB), .uCmdB(uCmdB), .uIxtB(uIxtB),
		.regNC(regNC), .regMC(regMC), .regOC(regOC),
		.immC(immC), .uCmdC(uCmdC), .uIxtC(uIxtC)
	);

endmodule

// ==== sim/wexDecodeTb.sv ====
/* testbench for the WEX bundle decoder
   drives random and directed fetch windows, checks bundles against a model */
`timescale 1ns/1ns
`include "wexDec_macros.svh"

module wexDecodeTb import wexDecPkg::*; ();

	logic        clock, rstN, fetchValid, modeWrite, modeWexEnable, modeLane3Enable;
	fetchWindowT fetchWindow;
	logic        decodeValid;
	opWordsT     opWords;
	regIdT       regNA, regMA, regOA, regNB, regMB, regOB, regNC, regMC, regOC;
	immT         immA, immB, immC;
	uCmdT        uCmdA, uCmdB, uCmdC;
	uIxtT        uIxtA, uIxtB, uIxtC;
	logic [1:0]  modeRead;

	logic [208:0] expQ [$];  // {opWords, lane A, lane B, lane C}
	logic [208:0] expBundle;
	logic         expValid, modelWex, modelL3;
	int           errCount;
	integer       seed;
	logic [31:0]  r;
	fetchWindowT  win;

	wexDecodeTop wexDecodeTop_inst (.*);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// slot field rule
	function automatic logic slotIsOp(input slotWordT w);
		return (w[15:13] == 3'b111) && (w[15:9] != `JUMBO_TAG);
	endfunction

	function automatic logic slotWex(input slotWordT w);
		return (w[15:12] == `GRP_PRED) ? (w[11] & w[9]) : w[10];
	endfunction

	function automatic logic [68:0] slotLane(input slotWordT w, input logic [32:0] immVal);
		logic [2:0] pcls;
		pcls = (w[15:12] == `GRP_PRED) ? (w[10] ? `PCLS_FALSE : `PCLS_TRUE) : `PCLS_UNCOND;
		return {w[21:16], w[27:22], w[7:6], w[31:28], immVal, pcls, w[5:0], 1'b0, w[7:0]};
	endfunction

	// bundle rule in priority order
	function automatic logic [208:0] bundleOf(input fetchWindowT w, input logic wexEn,
		input logic l3En);
		slotWordT    s0, s1, s2;
		logic [68:0] idle, inv;
		logic        lead;
		s0 = w[31:0];
		s1 = w[63:32];
		s2 = w[95:64];
		idle = {`GR_ZZR, `GR_ZZR, `GR_ZZR, 51'd0};
		inv = {`GR_ZZR, `GR_ZZR, `GR_ZZR, 33'd0, `PCLS_UNCOND, `UCMD_INVOP, 9'd0};
		lead = slotIsOp(s0) && wexEn && slotWex(s0) && slotIsOp(s1);
		if ((s0[15:9] == `JUMBO_TAG) && slotIsOp(s1))
			return {2'd2, slotLane(s1, {s0[7:0], s0[31:16], s1[31:23]}), idle, idle};
		if (lead && slotWex(s1) && l3En && slotIsOp(s2))
			return {2'd3, slotLane(s2, {{23{s2[31]}}, s2[31:22]}),
				slotLane(s1, {{23{s1[31]}}, s1[31:22]}), slotLane(s0, {{23{s0[31]}}, s0[31:22]})};
		if (lead)
			return {2'd2, slotLane(s1, {{23{s1[31]}}, s1[31:22]}),
				slotLane(s0, {{23{s0[31]}}, s0[31:22]}), idle};
		if (slotIsOp(s0))
			return {2'd1, slotLane(s0, {{23{s0[31]}}, s0[31:22]}), idle, idle};
		return {2'd1, inv, idle, idle};
	endfunction

	// kind 0 jumbo, 1 predicated, 2 unconditional, 3 other
	function automatic slotWordT makeSlot(input slotWordT raw, input logic [1:0] kind,
		input logic wex);
		slotWordT s;
		s = raw;
		case (kind)
			2'd0: s[15:9] = `JUMBO_TAG;
			2'd1:
			begin
				s[15:12] = `GRP_PRED;
				s[9] = wex | s[9];
				s[11] = wex | (s[11] & ~s[9]);  // both set only for a wex op
			end
			2'd2:
			begin
				s[15:12] = `GRP_UNCOND;
				s[10] = wex;
				s[11] = s[11] & ~(s[10] & s[9]);  // keeps it clear of the jumbo tag
			end
			default: s[15] = s[15] & ~(s[14] & s[13]);  // any group below Ex
		endcase
		return s;
	endfunction

	task automatic buildWindow(input logic [1:0] k0, k1, k2, input logic [2:0] wex,
		output fetchWindowT w);
		w[31:0] = makeSlot($random(seed), k0, wex[0]);
		w[63:32] = makeSlot($random(seed), k1, wex[1]);
		w[95:64] = makeSlot($random(seed), k2, wex[2]);
	endtask

	task automatic randomWindow(output fetchWindowT w);
		logic [31:0] pick;
		logic [1:0]  kind;
		for (int i = 0; i < 3; i++)
		begin
			pick = $random(seed);
			kind = (pick[3:0] < 2) ? 2'd0 : (pick[3:0] < 7) ? 2'd1 : (pick[3:0] < 12) ? 2'd2 : 2'd3;
			w[32*i +: 32] = makeSlot($random(seed), kind, pick[4]);
		end
	endtask

	task automatic checkField(input string name, input logic [63:0] exp, act);
		if (exp !== act)
		begin
			errCount++;
			$display("ERR %0t %s exp=%0h act=%0h", $time, name, exp, act);
		end
	endtask

	task automatic checkLane(input string tag, input logic [68:0] l, input regIdT n, m, o,
		input immT i, input uCmdT c, input uIxtT x);
		checkField({"regN", tag}, 64'(l[68:63]), 64'(n));
		checkField({"regM", tag}, 64'(l[62:57]), 64'(m));
		checkField({"regO", tag}, 64'(l[56:51]), 64'(o));
		checkField({"imm", tag}, 64'(l[50:18]), 64'(i));
		checkField({"uCmd", tag}, 64'(l[17:9]), 64'(c));
		checkField({"uIxt", tag}, 64'(l[8:0]), 64'(x));
	endtask

	// model queues the bundle with the mode in force at the sampling edge
	task automatic driveCycle(input logic valid, input fetchWindowT w, input logic mWrite,
		input logic mWex, input logic mL3);
		@(posedge clock);
		#1;
		fetchValid = valid;
		fetchWindow = w;
		modeWrite = mWrite;
		modeWexEnable = mWex;
		modeLane3Enable = mL3;
		if (valid)
			expQ.push_back(bundleOf(w, modelWex, modelL3));
		if (mWrite)
		begin
			modelWex = mWex;
			modelL3 = mL3;
		end
	endtask

	task automatic waitDrained();
		int waitCount;
		waitCount = 0;
		while ((expQ.size() != 0) && (waitCount < 20))
		begin
			@(negedge clock);
			waitCount++;
		end
		if (expQ.size() != 0)
		begin
			errCount++;
			$display("timeout, %0d bundles never showed up on decodeValid", expQ.size());
			$display("errors: %0d", errCount);
			$display("ERRORS FOUND");
			$finish;
		end
	endtask

	task automatic sendOne(input fetchWindowT w);
		driveCycle(1'b1, w, 1'b0, 1'b0, 1'b0);
		driveCycle(1'b0, '0, 1'b0, 1'b0, 1'b0);
		waitDrained();
	endtask

	always @(posedge clock)
		expValid <= rstN && fetchValid;  // pulse due one edge later

	always @(negedge clock)
	begin
		if (rstN)
		begin
			checkField("decodeValid", 64'(expValid), 64'(decodeValid));
			if (decodeValid === 1'b1)
			begin
				if (expQ.size() == 0)
				begin
					errCount++;
					$display("decodeValid pulsed at %0t with no bundle expected", $time);
				end
				else
				begin
					expBundle = expQ.pop_front();
					checkField("opWords", 64'(expBundle[208:207]), 64'(opWords));
					checkLane("A", expBundle[206:138], regNA, regMA, regOA, immA, uCmdA, uIxtA);
					checkLane("B", expBundle[137:69], regNB, regMB, regOB, immB, uCmdB, uIxtB);
					checkLane("C", expBundle[68:0], regNC, regMC, regOC, immC, uCmdC, uIxtC);
				end
			end
		end
	end

	initial
	begin
		seed = 32'h7a9694f0;
		errCount = 0;
		modelWex = 1'b1;
		modelL3 = 1'b1;
		rstN = 1'b0;
		fetchValid = 1'b0;
		fetchWindow = '0;
		modeWrite = 1'b0;
		modeWexEnable = 1'b0;
		modeLane3Enable = 1'b0;
		repeat (4) @(posedge clock);
		#1 rstN = 1'b1;
		@(negedge clock);
		checkField("opWords", 64'd0, 64'(opWords));
		checkLane("A", 69'd0, regNA, regMA, regOA, immA, uCmdA, uIxtA);
		checkLane("B", 69'd0, regNB, regMB, regOB, immB, uCmdB, uIxtB);
		checkLane("C", 69'd0, regNC, regMC, regOC, immC, uCmdC, uIxtC);
		checkField("modeRead", 64'(`MODE_RESET), 64'(modeRead));

		buildWindow(2'd1, 2'd3, 2'd3, 3'b000, win);  // predicated scalar
		sendOne(win);
		buildWindow(2'd2, 2'd1, 2'd2, 3'b000, win);  // unconditional scalar
		sendOne(win);
		buildWindow(2'd3, 2'd1, 2'd1, 3'b111, win);  // invalid op
		sendOne(win);
		buildWindow(2'd1, 2'd3, 2'd1, 3'b001, win);  // wex flag but slot 1 not an op
		sendOne(win);
		buildWindow(2'd1, 2'd2, 2'd3, 3'b011, win);  // WEX2
		sendOne(win);
		buildWindow(2'd2, 2'd1, 2'd2, 3'b011, win);  // WEX3
		sendOne(win);
		buildWindow(2'd0, 2'd1, 2'd3, 3'b000, win);  // jumbo prefix
		sendOne(win);

		// same three-wide window under each mode
		buildWindow(2'd1, 2'd2, 2'd1, 3'b011, win);
		driveCycle(1'b1, win, 1'b1, 1'b1, 1'b0);
		driveCycle(1'b0, '0, 1'b0, 1'b0, 1'b0);
		waitDrained();
		checkField("modeRead", 64'd1, 64'(modeRead));
		sendOne(win);
		driveCycle(1'b0, '0, 1'b1, 1'b0, 1'b1);
		sendOne(win);
		checkField("modeRead", 64'd2, 64'(modeRead));
		driveCycle(1'b0, '0, 1'b1, 1'b1, 1'b1);

		for (int n = 0; n < 400; n++)
		begin
			r = $random(seed);
			randomWindow(win);
			driveCycle(r[1:0] != 2'b00, win, r[6:2] == 5'd0, r[7], r[8] | r[9]);
		end
		driveCycle(1'b0, '0, 1'b0, 1'b0, 1'b0);
		waitDrained();

		$display("errors: %0d", errCount);
		if (errCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== wexDecode.f ====
+incdir+hdl
hdl/wexDecPkg.sv
hdl/modeReg.sv
hdl/slotDecoder.sv
hdl/laneRouter.sv
hdl/wexDecodeTop.sv
sim/wexDecodeTb.sv
